//--- tpu_cfg.svh
// Sizing macros for the external data-memory path of the tensor unit
`ifndef TPU_CFG_SVH
`define TPU_CFG_SVH

// Data word width
`define TPU_DATA_W		32

// Address, length and stride width
`define TPU_ADDR_W		10

`define TPU_N_CHAN		4		// Host channels sharing the input stream

`define TPU_BUFF_SIZE	16		// Ring buffer entries per handler

`define TPU_MEM_DEPTH	1024	// Words in the data memory

`endif

//--- pkg_tpu.sv
// Shared word, address, command and state types of the external memory path
`default_nettype none
`include "tpu_cfg.svh"

package pkg_tpu;

	typedef logic [`TPU_DATA_W-1:0]			data_t;
	typedef logic [`TPU_ADDR_W-1:0]			address_t;
	typedef logic [$clog2(`TPU_N_CHAN)-1:0]	chan_t;

	// Opcode from bit 0 of the stride word
	typedef enum logic {
		MODE_STORE	= 1'b0,
		MODE_LOAD	= 1'b1
	} mode_t;

	typedef enum logic [2:0] {
		SERV_INIT,			// Waiting for stride word
		SERV_RECV_LENGTH,
		SERV_RECV_BASE,
		SERV_ST_BUFF,		// Collecting store data
		SERV_ST_REQ,
		SERV_ST_RUN,
		SERV_LD_REQ,
		SERV_LD_RUN
	} serv_state_t;

	typedef struct packed {
		logic		req;
		chan_t		chan;
		data_t		data;
		logic		rls;
	} ext_in_t;

	typedef struct packed {
		logic		req;
		data_t		data;
		logic		rls;		// Last word of a load
	} ext_out_t;

	typedef struct packed {
		address_t	length;
		address_t	stride;
		address_t	base;
		mode_t		mode;
	} mem_cmd_t;

endpackage

`default_nettype wire

//--- ring_buff_ctrl.sv
// Pointer and occupancy control for one circular buffer
`timescale 1ns/100ps
`default_nettype none

module ring_buff_ctrl #(
	parameter int NUM_ENTRY = 16
) (
	input wire							clock,
	input wire							reset,
	input wire							we,
	input wire							re,
	input wire							clear,		// Drops all entries
	output logic [$clog2(NUM_ENTRY)-1:0]	wr_ptr,
	output logic [$clog2(NUM_ENTRY)-1:0]	rd_ptr,
	output logic						full,
	output logic						empty,
	output logic [$clog2(NUM_ENTRY):0]	num
);

	localparam int PTR_W = $clog2(NUM_ENTRY);

	always_ff @(posedge clock) begin
		if (reset || clear) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			num		<= '0;
		end else begin
			if (we) begin
				wr_ptr	<= (wr_ptr == PTR_W'(NUM_ENTRY - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (re) begin
				rd_ptr	<= (rd_ptr == PTR_W'(NUM_ENTRY - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({we, re})
				2'b10:		num <= num + 1'b1;
				2'b01:		num <= num - 1'b1;
				default:	num <= num;		// Both or neither
			endcase
		end
	end

	assign full		= (num == (PTR_W + 1)'(NUM_ENTRY));
	assign empty	= (num == '0);

	a_no_overflow: assert property (@(posedge clock) disable iff (reset) we |-> !full);
	a_no_underflow: assert property (@(posedge clock) disable iff (reset) re |-> !empty);

endmodule

`default_nettype wire

//--- extern_handle.sv
// Per-channel command receiver, store/load sequencer and data buffer
`timescale 1ns/100ps
`default_nettype none
`include "tpu_cfg.svh"

module extern_handle #(
	parameter int BUFF_SIZE = `TPU_BUFF_SIZE
) (
	input wire						clock,
	input wire						reset,
	input wire pkg_tpu::ext_in_t	chan_in,
	output pkg_tpu::ext_out_t		ext_out,
	output pkg_tpu::mem_cmd_t		cmd,
	output logic					mem_req,
	input wire						grant,
	input wire						st_pop,
	input wire						ld_valid,
	input wire						term,
	output pkg_tpu::data_t			st_data,
	input wire pkg_tpu::data_t		ld_data
);

	localparam int BUFF_W = $clog2(BUFF_SIZE);

	pkg_tpu::serv_state_t	state;
	pkg_tpu::mode_t			r_mode;
	pkg_tpu::address_t		r_stride;
	pkg_tpu::address_t		r_length;
	pkg_tpu::address_t		r_base;
	pkg_tpu::address_t		ld_cnt;		// Loaded words forwarded so far

	pkg_tpu::data_t			buff [BUFF_SIZE];
	logic					we, re, re_ld;
	logic [BUFF_W-1:0]		wr_ptr, rd_ptr;
	logic					empty;
	logic [BUFF_W:0]		num;

	logic					cmd_word;
	logic					abort;
	logic					in_run;

	assign cmd_word	= chan_in.req & ~chan_in.rls;
	assign in_run	= (state == pkg_tpu::SERV_ST_RUN) || (state == pkg_tpu::SERV_LD_RUN);
	assign abort	= chan_in.req & chan_in.rls & ~in_run & ~grant;

	////////////////////
	// Command capture

	// Stride word carries the mode in bit 0, the stride above it
	always_ff @(posedge clock) begin
		if (state == pkg_tpu::SERV_INIT && cmd_word) begin
			r_stride	<= chan_in.data[`TPU_ADDR_W:1];
		end
		if (state == pkg_tpu::SERV_RECV_LENGTH && cmd_word) begin
			r_length	<= chan_in.data[`TPU_ADDR_W-1:0];
		end
		if (state == pkg_tpu::SERV_RECV_BASE && cmd_word) begin
			r_base		<= chan_in.data[`TPU_ADDR_W-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			r_mode	<= pkg_tpu::MODE_STORE;
		end else if (state == pkg_tpu::SERV_INIT && cmd_word) begin
			r_mode	<= pkg_tpu::mode_t'(chan_in.data[0]);
		end
	end

	assign cmd		= '{length: r_length, stride: r_stride, base: r_base, mode: r_mode};
	assign mem_req	= (state == pkg_tpu::SERV_ST_REQ) || (state == pkg_tpu::SERV_LD_REQ);

	////////////////////
	// Service FSM

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= pkg_tpu::SERV_INIT;
		end else begin
			case (state)
				pkg_tpu::SERV_INIT: begin
					if (cmd_word) state <= pkg_tpu::SERV_RECV_LENGTH;
				end
				pkg_tpu::SERV_RECV_LENGTH: begin
					if (abort) state <= pkg_tpu::SERV_INIT;
					else if (cmd_word) state <= pkg_tpu::SERV_RECV_BASE;
				end
				pkg_tpu::SERV_RECV_BASE: begin
					if (abort) state <= pkg_tpu::SERV_INIT;
					else if (cmd_word) begin
						state <= (r_mode == pkg_tpu::MODE_LOAD) ? pkg_tpu::SERV_LD_REQ
							: pkg_tpu::SERV_ST_BUFF;
					end
				end
				pkg_tpu::SERV_ST_BUFF: begin
					if (abort) state <= pkg_tpu::SERV_INIT;
					else if (cmd_word && (pkg_tpu::address_t'(num) + 1'b1 == r_length)) begin
						state <= pkg_tpu::SERV_ST_REQ;
					end
				end
				// A grant in the same cycle as a release wins
				pkg_tpu::SERV_ST_REQ: begin
					if (grant) state <= pkg_tpu::SERV_ST_RUN;
					else if (abort) state <= pkg_tpu::SERV_INIT;
				end
				pkg_tpu::SERV_LD_REQ: begin
					if (grant) state <= pkg_tpu::SERV_LD_RUN;
					else if (abort) state <= pkg_tpu::SERV_INIT;
				end
				pkg_tpu::SERV_ST_RUN, pkg_tpu::SERV_LD_RUN: begin
					if (term) state <= pkg_tpu::SERV_INIT;
				end
				default: state <= pkg_tpu::SERV_INIT;
			endcase
		end
	end

	////////////////////
	// Data buffer

	// Load words sit here for exactly one cycle
	assign re_ld	= (r_mode == pkg_tpu::MODE_LOAD) & ~empty;
	assign we		= (state == pkg_tpu::SERV_ST_BUFF && cmd_word) || ld_valid;
	assign re		= st_pop | re_ld;

	always_ff @(posedge clock) begin
		if (we) begin
			buff[wr_ptr] <= ld_valid ? ld_data : chan_in.data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_cnt <= '0;
		end else if (state == pkg_tpu::SERV_RECV_BASE && cmd_word) begin
			ld_cnt <= '0;
		end else if (re_ld) begin
			ld_cnt <= ld_cnt + 1'b1;
		end
	end

	assign st_data		= buff[rd_ptr];
	assign ext_out.req	= re_ld;
	assign ext_out.data	= buff[rd_ptr];
	assign ext_out.rls	= re_ld & (ld_cnt == r_length - 1'b1);

	ring_buff_ctrl #(
		.NUM_ENTRY	(BUFF_SIZE)
	) u_ring (
		.clock		(clock),
		.reset		(reset),
		.we			(we),
		.re			(re),
		.clear		(abort),
		.wr_ptr		(wr_ptr),
		.rd_ptr		(rd_ptr),
		.full		(),
		.empty		(empty),
		.num		(num)
	);

	a_grant_on_req: assert property (@(posedge clock) disable iff (reset) grant |-> mem_req);

endmodule

`default_nettype wire

//--- extern_router.sv
// Registers each host word and steers it to its channel's handler
`timescale 1ns/100ps
`default_nettype none
`include "tpu_cfg.svh"

module extern_router (
	input wire								clock,
	input wire								reset,
	input wire pkg_tpu::ext_in_t			ext_in,
	output pkg_tpu::ext_in_t [`TPU_N_CHAN-1:0]	chan_in
);

	logic				req_q;
	pkg_tpu::chan_t		chan_q;
	pkg_tpu::data_t		data_q;
	logic				rls_q;

	always_ff @(posedge clock) begin
		if (reset) req_q <= 1'b0;
		else req_q <= ext_in.req;
	end

	always_ff @(posedge clock) begin
		chan_q	<= ext_in.chan;
		data_q	<= ext_in.data;
		rls_q	<= ext_in.rls;
	end

	// One-hot request, payload shared
	always_comb begin
		for (int i = 0; i < `TPU_N_CHAN; i++) begin
			chan_in[i].req	= req_q & (chan_q == pkg_tpu::chan_t'(i));
			chan_in[i].chan	= chan_q;
			chan_in[i].data	= data_q;
			chan_in[i].rls	= rls_q;
		end
	end

	a_chan_range: assert property (@(posedge clock) disable iff (reset)
		req_q |-> (int'(chan_q) < `TPU_N_CHAN));

endmodule

`default_nettype wire

//--- strided_mem.sv
// Round-robin arbiter, strided address generator and data memory array
`timescale 1ns/100ps
`default_nettype none
`include "tpu_cfg.svh"

module strided_mem (
	input wire									clock,
	input wire									reset,
	input wire pkg_tpu::mem_cmd_t [`TPU_N_CHAN-1:0]	cmd,
	input wire [`TPU_N_CHAN-1:0]				mem_req,
	output logic [`TPU_N_CHAN-1:0]				grant,
	output logic [`TPU_N_CHAN-1:0]				st_pop,
	output logic [`TPU_N_CHAN-1:0]				ld_valid,
	output logic [`TPU_N_CHAN-1:0]				term,
	input wire pkg_tpu::data_t [`TPU_N_CHAN-1:0]	st_data,
	output pkg_tpu::data_t						ld_data
);

	localparam int MEM_AW = $clog2(`TPU_MEM_DEPTH);

	logic					busy;
	pkg_tpu::chan_t			sel, last_srv, pick;
	logic					pick_ok;
	pkg_tpu::mem_cmd_t		cur;
	pkg_tpu::address_t		addr, cnt;
	logic					last_word;
	pkg_tpu::data_t			mem [`TPU_MEM_DEPTH];

	////////////////////
	// Round-robin pick

	// Search starts one past the last served channel
	always_comb begin
		int idx;
		pick	= last_srv;
		pick_ok	= 1'b0;
		for (int i = 1; i <= `TPU_N_CHAN; i++) begin
			idx = (int'(last_srv) + i) % `TPU_N_CHAN;
			if (!pick_ok && mem_req[idx]) begin
				pick	= pkg_tpu::chan_t'(idx);
				pick_ok	= 1'b1;
			end
		end
	end

	assign last_word = busy && (cnt == cur.length - 1'b1);

	always_comb begin
		grant		= '0;
		st_pop		= '0;
		ld_valid	= '0;
		term		= '0;
		grant[pick]	= ~busy & pick_ok;
		st_pop[sel]	= busy & (cur.mode == pkg_tpu::MODE_STORE);
		ld_valid[sel]	= busy & (cur.mode == pkg_tpu::MODE_LOAD);
		term[sel]	= last_word;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy		<= 1'b0;
			last_srv	<= '0;
		end else if (|grant) begin
			busy		<= 1'b1;
			last_srv	<= pick;
		end else if (last_word) begin
			busy		<= 1'b0;	// Free again next cycle
		end
	end

	////////////////////
	// Address walk

	always_ff @(posedge clock) begin
		if (|grant) begin
			sel		<= pick;
			cur		<= cmd[pick];
			addr	<= cmd[pick].base;
			cnt		<= '0;
		end else if (busy) begin
			addr	<= addr + cur.stride;	// Wraps with the address width
			cnt		<= cnt + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (busy && cur.mode == pkg_tpu::MODE_STORE) begin
			mem[addr[MEM_AW-1:0]] <= st_data[sel];
		end
	end

	assign ld_data = mem[addr[MEM_AW-1:0]];		// Async read, valid with ld_valid

	a_grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant));

endmodule

`default_nettype wire

//--- extern_subsys.sv
// External-port subsystem joining router, channel handlers and strided memory
`timescale 1ns/100ps
`default_nettype none
`include "tpu_cfg.svh"

module extern_subsys (
	input wire									clock,
	input wire									reset,
	input wire pkg_tpu::ext_in_t				ext_in,
	output pkg_tpu::ext_out_t [`TPU_N_CHAN-1:0]	ext_out
);

	pkg_tpu::ext_in_t [`TPU_N_CHAN-1:0]		chan_in;
	pkg_tpu::mem_cmd_t [`TPU_N_CHAN-1:0]	cmd;
	pkg_tpu::data_t [`TPU_N_CHAN-1:0]		st_data;
	pkg_tpu::data_t							ld_data;
	logic [`TPU_N_CHAN-1:0]					mem_req, grant, st_pop, ld_valid, term;

	extern_router u_router (
		.clock		(clock),
		.reset		(reset),
		.ext_in		(ext_in),
		.chan_in	(chan_in)
	);

	for (genvar i = 0; i < `TPU_N_CHAN; i++) begin : g_chan
		extern_handle #(
			.BUFF_SIZE	(`TPU_BUFF_SIZE)
		) u_handle (
			.clock		(clock),
			.reset		(reset),
			.chan_in	(chan_in[i]),
			.ext_out	(ext_out[i]),
			.cmd		(cmd[i]),
			.mem_req	(mem_req[i]),
			.grant		(grant[i]),
			.st_pop		(st_pop[i]),
			.ld_valid	(ld_valid[i]),
			.term		(term[i]),
			.st_data	(st_data[i]),
			.ld_data	(ld_data)
		);
	end

	strided_mem u_mem (
		.clock		(clock),
		.reset		(reset),
		.cmd		(cmd),
		.mem_req	(mem_req),
		.grant		(grant),
		.st_pop		(st_pop),
		.ld_valid	(ld_valid),
		.term		(term),
		.st_data	(st_data),
		.ld_data	(ld_data)
	);

endmodule

`default_nettype wire

//--- tb_extern_subsys.sv
// Testbench for the external-port subsystem, driven from the tests file
`timescale 1ns/100ps
`default_nettype none
`include "tpu_cfg.svh"

module tb_extern_subsys;

	localparam int N_CHAN		= `TPU_N_CHAN;
	localparam int DEPTH		= `TPU_MEM_DEPTH;
	localparam int MAX_TESTS	= 64;

	logic								clock;
	logic								reset;
	pkg_tpu::ext_in_t					ext_in;
	pkg_tpu::ext_out_t [N_CHAN-1:0]		ext_out;

	// Tests file contents
	int		t_ch [MAX_TESTS];
	int		t_mode [MAX_TESTS];
	int		t_stride [MAX_TESTS];
	int		t_len [MAX_TESTS];
	int		t_base [MAX_TESTS];
	int		t_abort [MAX_TESTS];
	int		n_tests = 0;
	int		total_words = 0;
	int		limit_cycles = 0;

	// Reference memory and per-channel bookkeeping
	pkg_tpu::data_t		ref_mem [DEPTH];
	bit					ref_valid [DEPTH];
	pkg_tpu::data_t		st_buf [N_CHAN][`TPU_BUFF_SIZE];
	int					st_base [N_CHAN];
	int					st_stride [N_CHAN];
	int					st_len [N_CHAN];
	pkg_tpu::data_t		exp_data [N_CHAN][DEPTH];
	int					exp_len [N_CHAN];
	int					exp_idx [N_CHAN];
	logic [N_CHAN-1:0]	st_pend = '0;		// Store buffered, not yet written
	logic [N_CHAN-1:0]	ld_pend = '0;		// Load words still owed

	int		checks = 0;
	int		errors = 0;

	extern_subsys UUT (
		.clock		(clock),
		.reset		(reset),
		.ext_in		(ext_in),
		.ext_out	(ext_out)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	task automatic check_value(input string name, input pkg_tpu::data_t actual,
			input pkg_tpu::data_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic read_tests(input int fd);
		string	line;
		int		ch, mode, stride, len, base, abort;
		while (!$feof(fd) && n_tests < MAX_TESTS) begin
			if ($fgets(line, fd) == 0) break;
			// Header lines do not scan and drop out here
			if ($sscanf(line, "%d %d %d %d %h %d", ch, mode, stride, len, base, abort) == 6) begin
				t_ch[n_tests]		= ch;
				t_mode[n_tests]		= mode;
				t_stride[n_tests]	= stride;
				t_len[n_tests]		= len;
				t_base[n_tests]		= base;
				t_abort[n_tests]	= abort;
				total_words			+= len;
				n_tests++;
			end
		end
		if (n_tests == 0) begin
			errors++;
			$display("ERROR: no test lines found in extern_tests.txt");
		end
	endtask

	task automatic send_word(input int ch, input pkg_tpu::data_t data, input logic rls);
		@(posedge clock);
		ext_in <= '{req: 1'b1, chan: pkg_tpu::chan_t'(ch), data: data, rls: rls};
	endtask

	task automatic drive_idle();
		@(posedge clock);
		ext_in <= '0;
	endtask

	////////////////////
	// Command driver

	task automatic run_command(input int i);
		int					ch;
		int					addr;
		pkg_tpu::data_t		stride_word;
		ch			= t_ch[i];
		stride_word	= pkg_tpu::data_t'(t_stride[i] * 2 + t_mode[i]);	// Mode in bit 0
		// Own channel must be idle, and the other mode drained
		if (t_mode[i] == 0) begin
			while (ld_pend != '0 || st_pend[ch]) @(negedge clock);
		end else begin
			while (st_pend != '0 || ld_pend[ch]) @(negedge clock);
		end
		send_word(ch, stride_word, 1'b0);
		send_word(ch, pkg_tpu::data_t'(t_len[i]), 1'b0);
		if (t_abort[i] != 0) begin
			send_word(ch, '0, 1'b1);		// Release in place of the base word
		end else if (t_mode[i] == 0) begin
			st_base[ch]		= t_base[i];
			st_stride[ch]	= t_stride[i];
			st_len[ch]		= t_len[i];
			send_word(ch, pkg_tpu::data_t'(t_base[i]), 1'b0);
			for (int k = 0; k < t_len[i]; k++) begin
				st_buf[ch][k] = $urandom();
				send_word(ch, st_buf[ch][k], 1'b0);
			end
			st_pend[ch] = 1'b1;
		end else begin
			for (int k = 0; k < t_len[i]; k++) begin
				addr = (t_base[i] + k * t_stride[i]) % DEPTH;
				if (!ref_valid[addr]) begin
					errors++;
					$display("ERROR: test line %0d loads address %0h that was never stored",
						i, addr);
				end
				exp_data[ch][k] = ref_mem[addr];
			end
			exp_len[ch]	= t_len[i];
			exp_idx[ch]	= 0;
			ld_pend[ch]	= 1'b1;
			send_word(ch, pkg_tpu::data_t'(t_base[i]), 1'b0);
		end
		drive_idle();
	endtask

	////////////////////
	// Output monitor

	task automatic take_load_word(input int c);
		if (exp_idx[c] >= exp_len[c]) begin
			errors++;
			$display("ERROR: channel %0d put out a word with no load pending", c);
		end else begin
			check_value($sformatf("ext_out[%0d].data", c), ext_out[c].data,
				exp_data[c][exp_idx[c]]);
			check_value($sformatf("ext_out[%0d].rls", c), pkg_tpu::data_t'(ext_out[c].rls),
				pkg_tpu::data_t'(exp_idx[c] == exp_len[c] - 1));
			exp_idx[c]++;
			if (exp_idx[c] == exp_len[c]) begin
				ld_pend[c] = 1'b0;
			end
		end
	endtask

	// Memory write of a store is complete at its term pulse
	task automatic apply_store(input int c);
		int addr;
		for (int k = 0; k < st_len[c]; k++) begin
			addr			= (st_base[c] + k * st_stride[c]) % DEPTH;
			ref_mem[addr]	= st_buf[c][k];
			ref_valid[addr]	= 1'b1;
		end
		st_pend[c] = 1'b0;
	endtask

	task automatic check_idle_outputs();
		pkg_tpu::data_t req_bits;
		pkg_tpu::data_t rls_bits;
		req_bits = '0;
		rls_bits = '0;
		for (int c = 0; c < N_CHAN; c++) begin
			req_bits[c] = ext_out[c].req;
			rls_bits[c] = ext_out[c].rls;
		end
		check_value("ext_out.req", req_bits, '0);
		check_value("ext_out.rls", rls_bits, '0);
	endtask

	always @(negedge clock) begin
		if (!reset) begin
			for (int c = 0; c < N_CHAN; c++) begin
				if (ext_out[c].req) begin
					take_load_word(c);
				end else begin
					check_value($sformatf("ext_out[%0d].rls", c),
						pkg_tpu::data_t'(ext_out[c].rls), '0);
				end
				if (UUT.term[c] && st_pend[c]) begin
					apply_store(c);
				end
			end
		end
	end

	////////////////////
	// Main sequence

	initial begin
		int fd;
		void'($urandom(32'h0e4e_6eb4));
		reset	= 1'b1;
		ext_in	= '0;
		fd = $fopen("extern_tests.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open extern_tests.txt");
			$display("TEST FAILED");
			$finish;
		end else begin
			read_tests(fd);
			$fclose(fd);
			limit_cycles = 200 * n_tests + 40 * total_words;
			repeat (16) @(posedge clock);
			reset <= 1'b0;
			repeat (4) begin
				@(negedge clock);
				check_idle_outputs();
			end
			for (int i = 0; i < n_tests; i++) begin
				run_command(i);
			end
			while (st_pend != '0 || ld_pend != '0) @(negedge clock);
			repeat (4) @(negedge clock);		// Room for stray words
			$display("Checks: %0d, errors: %0d", checks, errors);
			if (errors == 0) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

	// Watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock);
		$display("ERROR: timeout after %0d cycles with stores or loads still pending",
			limit_cycles);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- extern_tests.txt
# channel mode(0 store, 1 load) stride length base(hex) abort
# Store lines carry random data words, an abort line sends a release after the length word
0 0 1 8 010 0
0 1 1 8 010 0
1 0 3 12 3f8 0
1 1 3 12 3f8 0
2 1 6 6 3f8 0
3 1 1 5 013 0
0 0 1 16 100 0
1 0 2 16 200 0
2 0 5 10 300 0
3 0 1 16 380 0
0 1 2 16 200 0
1 1 1 16 100 0
2 1 1 16 380 0
3 1 5 10 300 0
2 0 1 8 100 1
2 1 1 8 100 0
1 1 1 4 100 1
2 0 7 9 150 0
2 1 7 9 150 0
3 0 1 4 3fe 0
0 1 1 4 3fe 0
1 1 1023 3 001 0

//--- src.f
+incdir+.
pkg_tpu.sv
ring_buff_ctrl.sv
extern_handle.sv
extern_router.sv
strided_mem.sv
extern_subsys.sv
tb_extern_subsys.sv

//--- run_sim.sh
#!/bin/bash
# Builds the external-port subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_extern_subsys -f src.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
